//--- verilog/stopwatch_pkg.sv
package stopwatch_pkg;

    // field widths of the running time.
    localparam int unsigned HOURS_W   = 5;
    localparam int unsigned MINUTES_W = 6;
    localparam int unsigned SECONDS_W = 6;
    localparam int unsigned CENTI_W   = 7;

    // modulus of each field.
    localparam int unsigned HOURS_LIMIT   = 24;
    localparam int unsigned MINUTES_LIMIT = 60;
    localparam int unsigned SECONDS_LIMIT = 60;
    localparam int unsigned CENTI_LIMIT   = 100;

    // 100 MHz board clock.
    localparam int unsigned CS_DIV_DEFAULT      = 1_000_000; // one tick per 10 ms.
    localparam int unsigned REFRESH_DIV_DEFAULT = 50_000;    // 1 kHz scan edge rate.

    localparam int unsigned NUM_DIGITS = 8;
    localparam int unsigned DIGIT_SEL_W = $clog2(NUM_DIGITS);

    // segment pattern that turns a digit off.
    localparam logic [6:0] SEG_BLANK = 7'b111_1111;

    typedef struct packed {
        logic [HOURS_W-1:0]   hours;
        logic [MINUTES_W-1:0] minutes;
        logic [SECONDS_W-1:0] seconds;
        logic [CENTI_W-1:0]   centiseconds;
    } time_value_t;

endpackage

//--- verilog/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
    parameter int unsigned CS_DIV      = stopwatch_pkg::CS_DIV_DEFAULT,
    parameter int unsigned REFRESH_DIV = stopwatch_pkg::REFRESH_DIV_DEFAULT
) (
    input  logic clock,
    input  logic reset_n,
    output logic cs_tick,
    output logic refresh_wave
);

    localparam int unsigned CS_W      = (CS_DIV > 1) ? $clog2(CS_DIV) : 1;
    localparam int unsigned REFRESH_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

    logic [CS_W-1:0]      cs_count;
    logic [REFRESH_W-1:0] refresh_count;
    logic                 cs_last;
    logic                 refresh_last;

    assign cs_last      = (cs_count == CS_W'(CS_DIV - 1));
    assign refresh_last = (refresh_count == REFRESH_W'(REFRESH_DIV - 1));
    assign cs_tick      = cs_last;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cs_count <= '0;
        end else if (cs_last) begin
            cs_count <= '0;
        end else begin
            cs_count <= cs_count + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            refresh_count <= '0;
            refresh_wave  <= 1'b0;
        end else if (refresh_last) begin
            refresh_count <= '0;
            refresh_wave  <= ~refresh_wave; // half period done.
        end else begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    // the counter must never see back-to-back ticks.
    assert property (@(posedge clock) disable iff (!reset_n) cs_tick |=> !cs_tick)
        else $error("cs_tick high on two consecutive cycles");

endmodule

//--- verilog/stopwatch_control.sv
`timescale 1ns/1ps

module stopwatch_control (
    input  logic clock,
    input  logic reset_n,
    input  logic btn_start_stop,
    input  logic btn_clear,
    output logic run,
    output logic clear_pulse
);

    typedef struct packed {
        logic start_stop;
        logic clear;
    } buttons_t;

    buttons_t btn_raw;
    buttons_t sync_meta;
    buttons_t sync_q;
    buttons_t btn_prev;
    buttons_t btn_rise;

    assign btn_raw.start_stop = btn_start_stop;
    assign btn_raw.clear      = btn_clear;

    // two-flop synchronizer on both buttons.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= btn_raw;
            sync_q    <= sync_meta;
        end
    end

    assign btn_rise = sync_q & ~btn_prev;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            btn_prev    <= '0;
            run         <= 1'b0;
            clear_pulse <= 1'b0;
        end else begin
            btn_prev    <= sync_q;
            clear_pulse <= btn_rise.clear; // single cycle.
            if (btn_rise.start_stop) begin
                run <= ~run;
            end
        end
    end

endmodule

//--- verilog/stopwatch_counter.sv
`timescale 1ns/1ps

module stopwatch_counter (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       cs_tick,
    input  logic                       run,
    input  logic                       clear_pulse,
    output stopwatch_pkg::time_value_t time_now
);

    stopwatch_pkg::time_value_t count_q;

    logic cs_step;
    logic cs_wrap;
    logic sec_wrap;
    logic min_wrap;
    logic hour_wrap;

    // carry chain, each stage enabled by the wrap of the one below.
    assign cs_step   = cs_tick & run;
    assign cs_wrap   = cs_step && (count_q.centiseconds ==
                       stopwatch_pkg::CENTI_W'(stopwatch_pkg::CENTI_LIMIT - 1));
    assign sec_wrap  = cs_wrap && (count_q.seconds ==
                       stopwatch_pkg::SECONDS_W'(stopwatch_pkg::SECONDS_LIMIT - 1));
    assign min_wrap  = sec_wrap && (count_q.minutes ==
                       stopwatch_pkg::MINUTES_W'(stopwatch_pkg::MINUTES_LIMIT - 1));
    assign hour_wrap = min_wrap && (count_q.hours ==
                       stopwatch_pkg::HOURS_W'(stopwatch_pkg::HOURS_LIMIT - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (clear_pulse) begin
            count_q <= '0; // clear beats a tick.
        end else if (cs_step) begin
            if (cs_wrap) begin
                count_q.centiseconds <= '0;
            end else begin
                count_q.centiseconds <= count_q.centiseconds + 1'b1;
            end
            if (sec_wrap) begin
                count_q.seconds <= '0;
            end else if (cs_wrap) begin
                count_q.seconds <= count_q.seconds + 1'b1;
            end
            if (min_wrap) begin
                count_q.minutes <= '0;
            end else if (sec_wrap) begin
                count_q.minutes <= count_q.minutes + 1'b1;
            end
            if (hour_wrap) begin
                count_q.hours <= '0; // 23 rolls to 0.
            end else if (min_wrap) begin
                count_q.hours <= count_q.hours + 1'b1;
            end
        end
    end

    assign time_now = count_q;

    assert property (@(posedge clock) disable iff (!reset_n)
        (time_now.centiseconds < stopwatch_pkg::CENTI_LIMIT) &&
        (time_now.seconds < stopwatch_pkg::SECONDS_LIMIT) &&
        (time_now.minutes < stopwatch_pkg::MINUTES_LIMIT) &&
        (time_now.hours < stopwatch_pkg::HOURS_LIMIT))
        else $error("time field out of range");

    // stopped and not cleared means frozen.
    assert property (@(posedge clock) disable iff (!reset_n)
        (!run && !clear_pulse) |=> $stable(time_now))
        else $error("time changed while stopped");

endmodule

//--- verilog/seven_segment_display.sv
`timescale 1ns/1ps

module seven_segment_display (
    input  logic                                  clock,
    input  logic                                  clock_refresh,
    input  logic                                  reset_n,
    input  stopwatch_pkg::time_value_t            time_now,
    output logic [6:0]                            seg,
    output logic [stopwatch_pkg::NUM_DIGITS-1:0]  an
);

    logic                                    refresh_prev;
    logic                                    refresh_rise;
    logic [stopwatch_pkg::DIGIT_SEL_W-1:0]   digit_select;
    logic [stopwatch_pkg::NUM_DIGITS-1:0][3:0] digits;
    logic [3:0]                              current_digit;
    logic [6:0]                              seg_pattern;

    // returns {tens, ones} of a value below 100.
    function automatic logic [7:0] split_decimal(input logic [6:0] value);
        logic [6:0] tens;
        logic [6:0] ones;
        tens = value / 7'd10;
        ones = value % 7'd10;
        return {tens[3:0], ones[3:0]};
    endfunction

    // edge of the scan wave, held one cycle in a register.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            refresh_prev <= 1'b0;
            refresh_rise <= 1'b0;
        end else begin
            refresh_prev <= clock_refresh;
            refresh_rise <= clock_refresh & ~refresh_prev;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            digit_select <= '0;
        end else if (refresh_rise) begin
            digit_select <= digit_select + 1'b1; // wraps after digit 7.
        end
    end

    // digit 0 is the rightmost one.
    assign digits[1:0] = split_decimal(time_now.centiseconds);
    assign digits[3:2] = split_decimal({1'b0, time_now.seconds});
    assign digits[5:4] = split_decimal({1'b0, time_now.minutes});
    assign digits[7:6] = split_decimal({2'b00, time_now.hours});

    assign current_digit = digits[digit_select];

    // segments gfedcba, active low.
    always_comb begin
        case (current_digit)
            4'd0:    seg_pattern = 7'b100_0000;
            4'd1:    seg_pattern = 7'b111_1001;
            4'd2:    seg_pattern = 7'b010_0100;
            4'd3:    seg_pattern = 7'b011_0000;
            4'd4:    seg_pattern = 7'b001_1001;
            4'd5:    seg_pattern = 7'b001_0010;
            4'd6:    seg_pattern = 7'b000_0010;
            4'd7:    seg_pattern = 7'b111_1000;
            4'd8:    seg_pattern = 7'b000_0000;
            4'd9:    seg_pattern = 7'b001_0000;
            default: seg_pattern = stopwatch_pkg::SEG_BLANK;
        endcase
    end

    always_comb begin
        an = '1;
        an[digit_select] = 1'b0;
    end

    // one cycle behind an.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            seg <= stopwatch_pkg::SEG_BLANK;
        end else begin
            seg <= seg_pattern;
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n) $onehot(~an))
        else $error("anode drive is not one-cold");

endmodule

//--- verilog/stopwatch_top.sv
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int unsigned CS_DIV      = stopwatch_pkg::CS_DIV_DEFAULT,
    parameter int unsigned REFRESH_DIV = stopwatch_pkg::REFRESH_DIV_DEFAULT
) (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 btn_start_stop,
    input  logic                                 btn_clear,
    output logic [6:0]                           seg,
    output logic [stopwatch_pkg::NUM_DIGITS-1:0] an
);

    logic                       cs_tick;
    logic                       refresh_wave;
    logic                       run;
    logic                       clear_pulse;
    stopwatch_pkg::time_value_t time_now;

    tick_divider #(
        .CS_DIV      (CS_DIV),
        .REFRESH_DIV (REFRESH_DIV)
    ) u_tick_divider (
        .clock        (clock),
        .reset_n      (reset_n),
        .cs_tick      (cs_tick),
        .refresh_wave (refresh_wave)
    );

    stopwatch_control u_control (
        .clock          (clock),
        .reset_n        (reset_n),
        .btn_start_stop (btn_start_stop),
        .btn_clear      (btn_clear),
        .run            (run),
        .clear_pulse    (clear_pulse)
    );

    stopwatch_counter u_counter (
        .clock       (clock),
        .reset_n     (reset_n),
        .cs_tick     (cs_tick),
        .run         (run),
        .clear_pulse (clear_pulse),
        .time_now    (time_now)
    );

    seven_segment_display u_display (
        .clock         (clock),
        .clock_refresh (refresh_wave),
        .reset_n       (reset_n),
        .time_now      (time_now),
        .seg           (seg),
        .an            (an)
    );

endmodule

//--- verif/stopwatch_tb.sv
`timescale 1ns/1ps

module stopwatch_tb;

    localparam int unsigned CS_DIV       = 4;
    localparam int unsigned REFRESH_DIV  = 2;
    localparam int unsigned NUM_RANDOM   = 12;
    localparam int unsigned SCAN_TIMEOUT = 4 * REFRESH_DIV * stopwatch_pkg::NUM_DIGITS;

    typedef enum logic [1:0] {
        ACT_WAIT,
        ACT_START_STOP,
        ACT_CLEAR
    } action_t;

    typedef struct packed {
        action_t     action;
        logic [15:0] ticks;
        logic        check;
        logic [31:0] expected_cs;
    } step_t;

    logic                                 clock;
    logic                                 reset_n;
    logic                                 btn_start_stop;
    logic                                 btn_clear;
    logic [6:0]                           seg;
    logic [stopwatch_pkg::NUM_DIGITS-1:0] an;

    int    edge_count;
    step_t steps[$];

    // active low, gfedcba, digits 0 to 9.
    logic [6:0] digit_patterns [10] = '{
        7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000, 7'b001_1001,
        7'b001_0010, 7'b000_0010, 7'b111_1000, 7'b000_0000, 7'b001_0000
    };

    stopwatch_top #(
        .CS_DIV      (CS_DIV),
        .REFRESH_DIV (REFRESH_DIV)
    ) uut (
        .clock          (clock),
        .reset_n        (reset_n),
        .btn_start_stop (btn_start_stop),
        .btn_clear      (btn_clear),
        .seg            (seg),
        .an             (an)
    );

    always #20 clock = ~clock;

    // posedges since reset release.
    always @(posedge clock) begin
        if (reset_n) begin
            edge_count <= edge_count + 1;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic stopwatch_pkg::time_value_t cs_to_time(input int total);
        stopwatch_pkg::time_value_t result;
        result.centiseconds = 7'(total % 100);
        result.seconds      = 6'((total / 100) % 60);
        result.minutes      = 6'((total / 6000) % 60);
        result.hours        = 5'((total / 360000) % 24);
        return result;
    endfunction

    function automatic logic [3:0] segment_to_digit(input logic [6:0] pattern);
        logic [3:0] digit;
        digit = 4'hf; // unknown pattern.
        for (int n = 0; n < 10; n++) begin
            if (pattern === digit_patterns[n]) begin
                digit = 4'(n);
            end
        end
        return digit;
    endfunction

    task automatic add_step(input action_t action, input int ticks, input logic check,
                            input int expected_cs);
        step_t s;
        s.action      = action;
        s.ticks       = 16'(ticks);
        s.check       = check;
        s.expected_cs = 32'(expected_cs);
        steps.push_back(s);
    endtask

    task automatic press_button(input action_t which);
        if (which == ACT_CLEAR) begin
            btn_clear = 1'b1;
        end else begin
            btn_start_stop = 1'b1;
        end
        @(negedge clock);
        btn_start_stop = 1'b0;
        btn_clear      = 1'b0;
    endtask

    task automatic wait_for_edge(input int target);
        int guard;
        int limit;
        guard = 0;
        limit = target - edge_count + 8;
        while (edge_count < target) begin
            @(negedge clock);
            guard++;
            if (guard > limit) begin
                abort_run($sformatf("timed out waiting for clock edge %0d", target));
            end
        end
    endtask

    // presses land where the edge count is a multiple of CS_DIV.
    task automatic align_to_tick_phase();
        int guard;
        guard = 0;
        while (edge_count % CS_DIV != 0) begin
            @(negedge clock);
            guard++;
            if (guard > CS_DIV) begin
                abort_run("timed out aligning to the tick phase");
            end
        end
    endtask

    task automatic read_display(output stopwatch_pkg::time_value_t shown);
        logic [3:0]                           digit_value [stopwatch_pkg::NUM_DIGITS];
        logic [stopwatch_pkg::NUM_DIGITS-1:0] want_an;
        int                                   guard;
        for (int d = 0; d < stopwatch_pkg::NUM_DIGITS; d++) begin
            want_an = ~(8'b0000_0001 << d);
            guard   = 0;
            check_value($countones(~an), 1, "exactly one anode active");
            while (an !== want_an) begin
                @(negedge clock);
                guard++;
                check_value($countones(~an), 1, "exactly one anode active");
                if (guard > SCAN_TIMEOUT) begin
                    abort_run($sformatf("display never selected digit %0d", d));
                end
            end
            @(negedge clock); // seg lags an by a cycle.
            digit_value[d] = segment_to_digit(seg);
            check_value(digit_value[d] < 10, 1, $sformatf("valid pattern on digit %0d", d));
        end
        shown.centiseconds = 7'(digit_value[1] * 10 + digit_value[0]);
        shown.seconds      = 6'(digit_value[3] * 10 + digit_value[2]);
        shown.minutes      = 6'(digit_value[5] * 10 + digit_value[4]);
        shown.hours        = 5'(digit_value[7] * 10 + digit_value[6]);
    endtask

    // two scans, so a stopped time must also hold still.
    task automatic check_display(input int idx, input int expected_cs);
        stopwatch_pkg::time_value_t expected;
        stopwatch_pkg::time_value_t shown;
        expected = cs_to_time(expected_cs);
        repeat (2) begin
            read_display(shown);
            check_value(32'(shown), 32'(expected),
                        $sformatf("display after step %0d, expected %0d:%0d:%0d.%0d", idx,
                                  expected.hours, expected.minutes, expected.seconds,
                                  expected.centiseconds));
        end
    endtask

    initial begin
        int   model_total;
        logic model_run;
        int   ticks;
        int   start_edge;
        clock          = 1'b0;
        reset_n        = 1'b0;
        btn_start_stop = 1'b0;
        btn_clear      = 1'b0;
        edge_count     = 0;
        void'($urandom(86));

        add_step(ACT_WAIT,       2,    1'b1, 0);    // idle after reset.
        add_step(ACT_START_STOP, 137,  1'b0, 0);
        add_step(ACT_START_STOP, 2,    1'b1, 137);  // 1.37 s.
        add_step(ACT_WAIT,       10,   1'b1, 137);
        add_step(ACT_CLEAR,      1,    1'b1, 0);    // clear while stopped.
        add_step(ACT_WAIT,       5,    1'b1, 0);
        add_step(ACT_START_STOP, 5999, 1'b0, 0);
        add_step(ACT_START_STOP, 2,    1'b1, 5999);
        add_step(ACT_START_STOP, 1,    1'b0, 0);
        add_step(ACT_START_STOP, 2,    1'b1, 6000); // carry into minutes.
        add_step(ACT_START_STOP, 40,   1'b0, 0);
        // the tick on the clear edge is lost, so 25 ticks leave 24.
        add_step(ACT_CLEAR,      25,   1'b0, 0);
        add_step(ACT_START_STOP, 2,    1'b1, 24);
        add_step(ACT_CLEAR,      1,    1'b1, 0);

        // reference model, stopped at zero here.
        model_total = 0;
        model_run   = 1'b0;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            ticks     = $urandom_range(300, 1);
            model_run = ~model_run;
            if (model_run) begin
                model_total += ticks;
            end
            add_step(ACT_START_STOP, ticks, !model_run, model_total);
        end

        repeat (5) @(negedge clock);
        reset_n = 1'b1;

        // run changes three edges after a press, so the ticks it covers
        // are those from one CS_DIV after the press up to the next press.
        foreach (steps[i]) begin
            start_edge = edge_count;
            if (steps[i].action != ACT_WAIT) begin
                press_button(steps[i].action);
            end
            wait_for_edge(start_edge + CS_DIV * int'(steps[i].ticks));
            if (steps[i].check) begin
                check_display(i, int'(steps[i].expected_cs));
            end
            align_to_tick_phase();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- stopwatch_top.f
verilog/stopwatch_pkg.sv
verilog/tick_divider.sv
verilog/stopwatch_control.sv
verilog/stopwatch_counter.sv
verilog/seven_segment_display.sv
verilog/stopwatch_top.sv
verif/stopwatch_tb.sv

//--- Bender.yml
package:
  name: stopwatch

sources:
  - verilog/stopwatch_pkg.sv
  - verilog/tick_divider.sv
  - verilog/stopwatch_control.sv
  - verilog/stopwatch_counter.sv
  - verilog/seven_segment_display.sv
  - verilog/stopwatch_top.sv
  - target: test
    files:
      - verif/stopwatch_tb.sv
